// File: Bender.yml
package:
  name: msp_dbg

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/msp_dbg_pkg.sv
      - rtl/msp_dbg_capture.sv
      - rtl/msp_dbg_state_text.sv
      - rtl/msp_dbg_disasm.sv
      - rtl/msp_dbg_top.sv
  - target: test
    files:
      - tb/msp_dbg_checker.sv
      - tb/tb_msp_dbg.sv

// File: include/msp_dbg_cfg.svh
`ifndef MSP_DBG_CFG_SVH
`define MSP_DBG_CFG_SVH

// ====================
// Text field geometry
// ====================

// Bytes per ASCII output field, 8 bits each
`define MSP_DBG_STR_BYTES 32

// ====================
// Special opcodes
// ====================

// MOV #0, r3 prints as NOP
`define MSP_DBG_NOP_OP 16'h4303

// Software breakpoint opcode
`define MSP_DBG_SWBRK_OP 16'h0001

`endif

// File: msp_dbg.f
+incdir+include
rtl/msp_dbg_pkg.sv
rtl/msp_dbg_capture.sv
rtl/msp_dbg_state_text.sv
rtl/msp_dbg_disasm.sv
rtl/msp_dbg_top.sv
tb/msp_dbg_checker.sv
tb/tb_msp_dbg.sv

// File: rtl/msp_dbg_capture.sv
module msp_dbg_capture
  import msp_dbg_pkg::*;
(
  input  logic        mclk,
  input  logic        puc_rst,
  input  core_trace_t i_core0,
  input  core_trace_t i_core1,
  input  logic        i_core_select,   // 1 selects core 1
  output inst_rec_t   o_rec,
  output logic [31:0] o_inst_number,
  output logic [31:0] o_inst_cycle,
  output i_state_e    o_sel_i_state,
  output e_state_e    o_sel_e_state
);

  // ====================
  // Core selection
  // ====================

  core_trace_t sel;

  assign sel = i_core_select ? i_core1 : i_core0;

  // Live state codes of the selected core
  assign o_sel_i_state = sel.i_state;
  assign o_sel_e_state = sel.e_state;

  // ====================
  // Decode capture
  // ====================

  // Reset record reads as the RESET vector entry
  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      o_rec.opcode  <= 16'h0000;
      o_rec.irq     <= 1'b1;
      o_rec.irq_num <= 4'hF;
      o_rec.pc      <= 16'h0000;
    end
    else if (sel.decode)
    begin
      o_rec.opcode  <= sel.ir;
      o_rec.irq     <= sel.irq_detect;
      o_rec.irq_num <= sel.irq_num;   // Held for the whole instruction
      o_rec.pc      <= sel.pc;
    end
  end

  // ====================
  // Counters
  // ====================

  // Instructions since reset
  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      o_inst_number <= 32'd0;
    end
    else if (sel.decode)
    begin
      o_inst_number <= o_inst_number + 32'd1;
    end
  end

  // Cycles within the current instruction
  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      o_inst_cycle <= 32'd0;
    end
    else if (sel.decode)
    begin
      o_inst_cycle <= 32'd0;
    end
    else
    begin
      o_inst_cycle <= o_inst_cycle + 32'd1;
    end
  end

endmodule

// File: rtl/msp_dbg_disasm.sv
`include "msp_dbg_cfg.svh"

module msp_dbg_disasm
  import msp_dbg_pkg::*;
(
  input  inst_rec_t i_rec,
  output dbg_text_t o_inst_short,
  output dbg_text_t o_inst_full
);

  // ====================
  // Text helpers
  // ====================

  // Append tail after head, optionally with one blank between them
  function automatic dbg_text_t txt_cat(
    input dbg_text_t head,
    input dbg_text_t tail,
    input logic      add_space
  );
    dbg_text_t res;
    int        len;
    int        gap;
    len = 0;
    for (int i = 0; i < `MSP_DBG_STR_BYTES; i++)
    begin
      if (tail[i] != 8'h00)
      begin
        len = i + 1;
      end
    end
    gap = add_space ? len + 1 : len;
    if (len == 0)
    begin
      res = head;                          // Empty tail adds nothing
    end
    else
    begin
      res = (head << (8 * gap)) | tail;
      if (add_space && (len < `MSP_DBG_STR_BYTES))
      begin
        res[len] = 8'h20;
      end
    end
    return res;
  endfunction

  // Decimal 0..15 as one or two digits
  function automatic dbg_text_t dec_txt(input logic [3:0] val);
    dbg_text_t res;
    res = '0;
    if (val < 4'd10)
    begin
      res[0] = 8'h30 + {4'h0, val};
    end
    else
    begin
      res[1] = 8'h31;
      res[0] = 8'h30 + {4'h0, val - 4'd10};
    end
    return res;
  endfunction

  // ====================
  // Classification
  // ====================

  inst_type_e  inst_type;
  logic [3:0]  src_reg;
  logic [3:0]  dst_reg;
  logic [1:0]  as_mode;
  dbg_text_t   src_reg_txt;
  dbg_text_t   dst_reg_txt;
  dbg_text_t   name_txt;
  dbg_text_t   bw_txt;
  dbg_text_t   src_txt;
  dbg_text_t   dst_txt;
  dbg_text_t   full_txt;

  always_comb
  begin
    if (i_rec.irq)
      inst_type = T_IRQ;
    else if (i_rec.opcode[15:13] == 3'b000)
      inst_type = T_SIG_OP;
    else if (i_rec.opcode[15:13] == 3'b001)
      inst_type = T_JUMP;
    else
      inst_type = T_TWO_OP;
  end

  assign src_reg     = (inst_type == T_SIG_OP) ? i_rec.opcode[3:0] : i_rec.opcode[11:8];
  assign dst_reg     = i_rec.opcode[3:0];
  assign as_mode     = i_rec.opcode[5:4];
  assign src_reg_txt = txt_cat("r", dec_txt(src_reg), 1'b0);
  assign dst_reg_txt = txt_cat("r", dec_txt(dst_reg), 1'b0);

  // ====================
  // Mnemonic
  // ====================

  always_comb
  begin
    name_txt = "xxxx";
    case (inst_type)
      T_IRQ :
      begin
        if (i_rec.irq_num == 4'hF)
          name_txt = "RESET";
        else if (i_rec.irq_num == 4'hE)
          name_txt = "NMI";
        else
          name_txt = txt_cat("IRQ", dec_txt(i_rec.irq_num), 1'b1);
      end
      T_SIG_OP :
      begin
        if (i_rec.opcode[15:10] == 6'b000100)
        begin
          case (i_rec.opcode[9:7])
            3'd0    : name_txt = "RRC";
            3'd1    : name_txt = "SWPB";
            3'd2    : name_txt = "RRA";
            3'd3    : name_txt = "SXT";
            3'd4    : name_txt = "PUSH";
            3'd5    : name_txt = "CALL";
            3'd6    : name_txt = "RETI";
            default : name_txt = "xxxx";
          endcase
        end
      end
      T_JUMP :
      begin
        case (i_rec.opcode[12:10])
          3'd0    : name_txt = "JNE";
          3'd1    : name_txt = "JEQ";
          3'd2    : name_txt = "JNC";
          3'd3    : name_txt = "JC";
          3'd4    : name_txt = "JN";
          3'd5    : name_txt = "JGE";
          3'd6    : name_txt = "JL";
          default : name_txt = "JMP";
        endcase
      end
      default :
      begin
        case (i_rec.opcode[15:12])
          4'h4    : name_txt = "MOV";
          4'h5    : name_txt = "ADD";
          4'h6    : name_txt = "ADDC";
          4'h7    : name_txt = "SUBC";
          4'h8    : name_txt = "SUB";
          4'h9    : name_txt = "CMP";
          4'hA    : name_txt = "DADD";
          4'hB    : name_txt = "BIT";
          4'hC    : name_txt = "BIC";
          4'hD    : name_txt = "BIS";
          4'hE    : name_txt = "XOR";
          4'hF    : name_txt = "AND";
          default : name_txt = "xxxx";
        endcase
      end
    endcase
  end

  // Byte suffix only on single- and two-operand formats
  assign bw_txt = ((inst_type == T_SIG_OP || inst_type == T_TWO_OP) && i_rec.opcode[6]) ?
                  dbg_text_t'(".B") : '0;

  // ====================
  // Operands
  // ====================

  always_comb
  begin
    src_txt = '0;
    if (inst_type == T_SIG_OP || inst_type == T_TWO_OP)
    begin
      if (src_reg == 4'd3)                 // Constant generator r3
      begin
        case (as_mode)
          2'd0    : src_txt = "#0";
          2'd1    : src_txt = "#1";
          2'd2    : src_txt = "#2";
          default : src_txt = "#-1";
        endcase
      end
      else if (src_reg == 4'd2)            // SR, absolute or constants
      begin
        case (as_mode)
          2'd0    : src_txt = src_reg_txt;
          2'd1    : src_txt = "&EDE";
          2'd2    : src_txt = "#4";
          default : src_txt = "#8";
        endcase
      end
      else if (src_reg == 4'd0)            // PC relative modes
      begin
        case (as_mode)
          2'd0    : src_txt = src_reg_txt;
          2'd1    : src_txt = "EDE";
          2'd2    : src_txt = txt_cat("@", src_reg_txt, 1'b0);
          default : src_txt = "#N";
        endcase
      end
      else
      begin
        case (as_mode)
          2'd0    : src_txt = src_reg_txt;
          2'd1    : src_txt = txt_cat(txt_cat("x(", src_reg_txt, 1'b0), ")", 1'b0);
          2'd2    : src_txt = txt_cat("@", src_reg_txt, 1'b0);
          default : src_txt = txt_cat(txt_cat("@", src_reg_txt, 1'b0), "+", 1'b0);
        endcase
      end
    end
  end

  always_comb
  begin
    dst_txt = '0;
    if (inst_type == T_TWO_OP)
    begin
      if (!i_rec.opcode[7])
        dst_txt = dst_reg_txt;
      else if (dst_reg == 4'd2)
        dst_txt = "&EDE";
      else if (dst_reg == 4'd0)
        dst_txt = "EDE";
      else
        dst_txt = txt_cat(txt_cat("x(", dst_reg_txt, 1'b0), ")", 1'b0);
    end
  end

  // ====================
  // Output text
  // ====================

  always_comb
  begin
    full_txt = txt_cat(name_txt, bw_txt, 1'b0);
    full_txt = txt_cat(full_txt, src_txt, 1'b1);
    if (inst_type == T_TWO_OP)
      full_txt = txt_cat(full_txt, ",", 1'b0);
    full_txt = txt_cat(full_txt, dst_txt, 1'b1);
    if (i_rec.opcode == `MSP_DBG_NOP_OP)
      full_txt = "NOP";
    if (i_rec.opcode == `MSP_DBG_SWBRK_OP)
      full_txt = "SBREAK";
  end

  assign o_inst_full  = full_txt;
  assign o_inst_short = name_txt;

endmodule

// File: rtl/msp_dbg_pkg.sv
`include "msp_dbg_cfg.svh"

package msp_dbg_pkg;

  // ====================
  // Frontend state codes
  // ====================

  // Instruction fetch FSM
  typedef enum logic [2:0] {
    I_IRQ_FETCH = 3'd0,
    I_IRQ_DONE  = 3'd1,
    I_DEC       = 3'd2,
    I_EXT1      = 3'd3,
    I_EXT2      = 3'd4,
    I_IDLE      = 3'd5
  } i_state_e;

  // Execution FSM, IRQ steps count down from IRQ_2
  typedef enum logic [3:0] {
    E_IRQ_2  = 4'd0,
    E_IRQ_1  = 4'd1,
    E_IRQ_0  = 4'd2,
    E_IRQ_3  = 4'd3,
    E_IRQ_4  = 4'd4,
    E_SRC_AD = 4'd5,
    E_SRC_RD = 4'd6,
    E_SRC_WR = 4'd7,
    E_DST_AD = 4'd8,
    E_DST_RD = 4'd9,
    E_DST_WR = 4'd10,
    E_EXEC   = 4'd11,
    E_JUMP   = 4'd12,
    E_IDLE   = 4'd13
  } e_state_e;

  // Instruction class
  typedef enum logic [1:0] {
    T_IRQ,
    T_SIG_OP,
    T_JUMP,
    T_TWO_OP
  } inst_type_e;

  // ====================
  // Trace records
  // ====================

  // Live frontend status of one core
  typedef struct packed {
    i_state_e    i_state;
    e_state_e    e_state;
    logic        decode;     // One-cycle strobe
    logic [15:0] ir;
    logic        irq_detect;
    logic [3:0]  irq_num;
    logic [15:0] pc;
  } core_trace_t;

  // Instruction latched at decode
  typedef struct packed {
    logic [15:0] opcode;
    logic        irq;
    logic [3:0]  irq_num;
    logic [15:0] pc;
  } inst_rec_t;

  // Right-aligned ASCII, NUL filled above the text
  typedef logic [`MSP_DBG_STR_BYTES-1:0][7:0] dbg_text_t;

endpackage

// File: rtl/msp_dbg_state_text.sv
module msp_dbg_state_text
  import msp_dbg_pkg::*;
(
  input  i_state_e  i_i_state,
  input  e_state_e  i_e_state,
  output dbg_text_t o_i_state_txt,
  output dbg_text_t o_e_state_txt
);

  // ====================
  // Fetch state names
  // ====================

  always_comb
  begin
    case (i_i_state)
      I_IRQ_FETCH : o_i_state_txt = "IRQ_FETCH";
      I_IRQ_DONE  : o_i_state_txt = "IRQ_DONE";
      I_DEC       : o_i_state_txt = "DEC";
      I_EXT1      : o_i_state_txt = "EXT1";
      I_EXT2      : o_i_state_txt = "EXT2";
      I_IDLE      : o_i_state_txt = "IDLE";
      default     : o_i_state_txt = "XXXXX";   // Codes 6 and 7
    endcase
  end

  // ====================
  // Execution state names
  // ====================

  always_comb
  begin
    case (i_e_state)
      E_IRQ_0  : o_e_state_txt = "IRQ_0";
      E_IRQ_1  : o_e_state_txt = "IRQ_1";
      E_IRQ_2  : o_e_state_txt = "IRQ_2";
      E_IRQ_3  : o_e_state_txt = "IRQ_3";
      E_IRQ_4  : o_e_state_txt = "IRQ_4";
      E_SRC_AD : o_e_state_txt = "SRC_AD";
      E_SRC_RD : o_e_state_txt = "SRC_RD";
      E_SRC_WR : o_e_state_txt = "SRC_WR";
      E_DST_AD : o_e_state_txt = "DST_AD";
      E_DST_RD : o_e_state_txt = "DST_RD";
      E_DST_WR : o_e_state_txt = "DST_WR";
      E_EXEC   : o_e_state_txt = "EXEC";
      E_JUMP   : o_e_state_txt = "JUMP";
      E_IDLE   : o_e_state_txt = "IDLE";
      default  : o_e_state_txt = "xxxx";   // Codes 14 and 15
    endcase
  end

endmodule

// File: rtl/msp_dbg_top.sv
module msp_dbg_top
  import msp_dbg_pkg::*;
(
  input  logic        mclk,
  input  logic        puc_rst,
  input  core_trace_t i_core0,
  input  core_trace_t i_core1,
  input  logic        i_core_select,
  output dbg_text_t   o_i_state,
  output dbg_text_t   o_e_state,
  output logic [31:0] o_inst_number,
  output logic [31:0] o_inst_cycle,
  output logic [15:0] o_inst_pc,
  output dbg_text_t   o_inst_short,
  output dbg_text_t   o_inst_full
);

  inst_rec_t rec;
  i_state_e  sel_i_state;
  e_state_e  sel_e_state;

  // Selection, decode capture and counters
  msp_dbg_capture u_capture (
    .mclk          (mclk),
    .puc_rst       (puc_rst),
    .i_core0       (i_core0),
    .i_core1       (i_core1),
    .i_core_select (i_core_select),
    .o_rec         (rec),
    .o_inst_number (o_inst_number),
    .o_inst_cycle  (o_inst_cycle),
    .o_sel_i_state (sel_i_state),
    .o_sel_e_state (sel_e_state)
  );

  // Live FSM names
  msp_dbg_state_text u_state_text (
    .i_i_state     (sel_i_state),
    .i_e_state     (sel_e_state),
    .o_i_state_txt (o_i_state),
    .o_e_state_txt (o_e_state)
  );

  msp_dbg_disasm u_disasm (
    .i_rec        (rec),
    .o_inst_short (o_inst_short),
    .o_inst_full  (o_inst_full)
  );

  assign o_inst_pc = rec.pc;   // PC of the captured instruction

endmodule

// File: tb/msp_dbg_checker.sv
module msp_dbg_checker
  import msp_dbg_pkg::*;
(
  input  logic        mclk,
  input  logic        puc_rst,
  input  core_trace_t i_core0,
  input  core_trace_t i_core1,
  input  logic        i_core_select,
  input  dbg_text_t   i_i_state,
  input  dbg_text_t   i_e_state,
  input  logic [31:0] i_inst_number,
  input  logic [31:0] i_inst_cycle,
  input  logic [15:0] i_inst_pc,
  input  dbg_text_t   i_inst_short,
  input  dbg_text_t   i_inst_full,
  input  dbg_text_t   i_exp_short,
  input  dbg_text_t   i_exp_full,
  input  logic [15:0] i_exp_pc,
  input  dbg_text_t   i_exp_i_state,
  input  dbg_text_t   i_exp_e_state,
  output int          o_err_count,
  output int          o_check_count
);

  timeunit 1ns;
  timeprecision 100ps;

  dbg_text_t   want_short;
  dbg_text_t   want_full;
  logic [15:0] want_pc;
  logic [31:0] want_number;
  logic [31:0] want_cycle;
  logic        sel_decode;

  initial
  begin
    o_err_count   = 0;
    o_check_count = 0;
  end

  // Only the selected core can update the monitor
  assign sel_decode = i_core_select ? i_core1.decode : i_core0.decode;

  task automatic check_text(input string what, input dbg_text_t got, input dbg_text_t exp);
    o_check_count++;
    if (got !== exp)
    begin
      o_err_count++;
      $display("ERR @%0t: %s is \"%0s\", expected \"%0s\"", $time, what, got, exp);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    o_check_count++;
    if (got !== exp)
    begin
      o_err_count++;
      $display("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // ====================
  // Reference model
  // ====================

  always @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      want_short  = "RESET";   // Reset vector entry
      want_full   = "RESET";
      want_pc     = 16'h0000;
      want_number = 32'd0;
      want_cycle  = 32'd0;
    end
    else if (sel_decode)
    begin
      want_short  = i_exp_short;
      want_full   = i_exp_full;
      want_pc     = i_exp_pc;
      want_number = want_number + 32'd1;
      want_cycle  = 32'd0;
    end
    else
    begin
      want_cycle = want_cycle + 32'd1;
    end
  end

  // ====================
  // Compare mid cycle
  // ====================

  always @(negedge mclk)
  begin
    if (puc_rst === 1'b0)
    begin
      check_text("inst_short", i_inst_short, want_short);
      check_text("inst_full", i_inst_full, want_full);
      check_value("inst_pc", {16'h0000, i_inst_pc}, {16'h0000, want_pc});
      check_value("inst_number", i_inst_number, want_number);
      check_value("inst_cycle", i_inst_cycle, want_cycle);
      check_text("i_state", i_i_state, i_exp_i_state);   // Live text
      check_text("e_state", i_e_state, i_exp_e_state);
    end
  end

endmodule

// File: tb/tb_msp_dbg.sv
module tb_msp_dbg
  import msp_dbg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // One table row, selected core trace plus expected text
  typedef struct packed {
    logic        sel;
    core_trace_t c0;
    core_trace_t c1;
    dbg_text_t   exp_short;
    dbg_text_t   exp_full;
    logic [15:0] exp_pc;
    dbg_text_t   exp_i_state;
    dbg_text_t   exp_e_state;
  } step_t;

  logic        mclk;
  logic        puc_rst;
  core_trace_t core0;
  core_trace_t core1;
  logic        core_select;
  dbg_text_t   exp_short;
  dbg_text_t   exp_full;
  logic [15:0] exp_pc;
  dbg_text_t   exp_i_state;
  dbg_text_t   exp_e_state;
  dbg_text_t   i_state_txt;
  dbg_text_t   e_state_txt;
  logic [31:0] inst_number;
  logic [31:0] inst_cycle;
  logic [15:0] inst_pc;
  dbg_text_t   inst_short;
  dbg_text_t   inst_full;
  int          err_count;
  int          check_count;
  logic        table_done;
  step_t       steps [32];
  int          n_steps;
  core_trace_t idle_trc;

  msp_dbg_top u_dut (
    .mclk          (mclk),
    .puc_rst       (puc_rst),
    .i_core0       (core0),
    .i_core1       (core1),
    .i_core_select (core_select),
    .o_i_state     (i_state_txt),
    .o_e_state     (e_state_txt),
    .o_inst_number (inst_number),
    .o_inst_cycle  (inst_cycle),
    .o_inst_pc     (inst_pc),
    .o_inst_short  (inst_short),
    .o_inst_full   (inst_full)
  );

  msp_dbg_checker u_checker (
    .mclk          (mclk),
    .puc_rst       (puc_rst),
    .i_core0       (core0),
    .i_core1       (core1),
    .i_core_select (core_select),
    .i_i_state     (i_state_txt),
    .i_e_state     (e_state_txt),
    .i_inst_number (inst_number),
    .i_inst_cycle  (inst_cycle),
    .i_inst_pc     (inst_pc),
    .i_inst_short  (inst_short),
    .i_inst_full   (inst_full),
    .i_exp_short   (exp_short),
    .i_exp_full    (exp_full),
    .i_exp_pc      (exp_pc),
    .i_exp_i_state (exp_i_state),
    .i_exp_e_state (exp_e_state),
    .o_err_count   (err_count),
    .o_check_count (check_count)
  );

  initial
  begin
    mclk = 1'b0;
    forever #4 mclk = ~mclk;
  end

  // ====================
  // Table helpers
  // ====================

  function automatic core_trace_t trc(input i_state_e ist, input e_state_e est,
                                      input logic dec, input logic [15:0] ir,
                                      input logic irq, input logic [3:0] num,
                                      input logic [15:0] pc);
    core_trace_t t;
    t.i_state    = ist;
    t.e_state    = est;
    t.decode     = dec;
    t.ir         = ir;
    t.irq_detect = irq;
    t.irq_num    = num;
    t.pc         = pc;
    return t;
  endfunction

  function automatic core_trace_t random_trace();
    logic [63:0] raw;
    raw = {$urandom, $urandom};
    return core_trace_t'(raw[$bits(core_trace_t)-1:0]);
  endfunction

  task automatic add_step(input logic sel, input core_trace_t c0, input core_trace_t c1,
                          input dbg_text_t short_txt, input dbg_text_t full_txt,
                          input logic [15:0] pc, input dbg_text_t ist, input dbg_text_t est);
    steps[n_steps] = {sel, c0, c1, short_txt, full_txt, pc, ist, est};
    n_steps++;
  endtask

  // Live row drives the decode, filler rows randomize the idle core
  task automatic drive_step(input step_t s, input logic live);
    core_trace_t a;
    core_trace_t b;
    a = s.c0;
    b = s.c1;
    if (!live)
    begin
      if (s.sel)
      begin
        b.decode = 1'b0;
        a = random_trace();
      end
      else
      begin
        a.decode = 1'b0;
        b = random_trace();
      end
    end
    core_select = s.sel;
    core0       = a;
    core1       = b;
    exp_short   = s.exp_short;
    exp_full    = s.exp_full;
    exp_pc      = s.exp_pc;
    exp_i_state = s.exp_i_state;
    exp_e_state = s.exp_e_state;
  endtask

  task automatic build_table();
    n_steps = 0;
    add_step(0, idle_trc, idle_trc, '0, '0, 16'h0, "IDLE", "IDLE");   // Record stays RESET
    add_step(0, trc(I_DEC, E_EXEC, 1, 16'h5A0B, 0, 4'd0, 16'hC000), idle_trc,
             "ADD", "ADD r10, r11", 16'hC000, "DEC", "EXEC");
    add_step(0, trc(I_EXT1, E_SRC_AD, 1, 16'h45F6, 0, 4'd0, 16'hC002), idle_trc,
             "MOV", "MOV.B @r5+, x(r6)", 16'hC002, "EXT1", "SRC_AD");
    add_step(0, trc(I_DEC, E_EXEC, 1, 16'h5314, 0, 4'd0, 16'hC006), idle_trc,
             "ADD", "ADD #1, r4", 16'hC006, "DEC", "EXEC");
    add_step(0, trc(I_DEC, E_EXEC, 1, 16'h8337, 0, 4'd0, 16'hC008), idle_trc,
             "SUB", "SUB #-1, r7", 16'hC008, "DEC", "EXEC");
    add_step(0, trc(I_DEC, E_EXEC, 1, 16'hD279, 0, 4'd0, 16'hC00A), idle_trc,
             "BIS", "BIS.B #8, r9", 16'hC00A, "DEC", "EXEC");
    add_step(0, trc(I_EXT1, E_SRC_RD, 1, 16'h921C, 0, 4'd0, 16'hC00C), idle_trc,
             "CMP", "CMP &EDE, r12", 16'hC00C, "EXT1", "SRC_RD");
    add_step(0, trc(I_DEC, E_SRC_WR, 1, 16'h1204, 0, 4'd0, 16'hC010), idle_trc,
             "PUSH", "PUSH r4", 16'hC010, "DEC", "SRC_WR");
    add_step(0, trc(I_DEC, E_JUMP, 1, 16'h3C05, 0, 4'd0, 16'hC012), idle_trc,
             "JMP", "JMP", 16'hC012, "DEC", "JUMP");
    add_step(0, trc(I_IRQ_FETCH, E_IRQ_1, 1, 16'h1234, 1, 4'd7, 16'hC014), idle_trc,
             "IRQ 7", "IRQ 7", 16'hC014, "IRQ_FETCH", "IRQ_1");
    add_step(0, trc(I_IRQ_DONE, E_IRQ_2, 1, 16'h1234, 1, 4'd14, 16'hC016), idle_trc,
             "NMI", "NMI", 16'hC016, "IRQ_DONE", "IRQ_2");
    add_step(0, trc(I_DEC, E_EXEC, 1, 16'h4303, 0, 4'd0, 16'hC018), idle_trc,
             "MOV", "NOP", 16'hC018, "DEC", "EXEC");
    add_step(0, trc(I_DEC, E_EXEC, 1, 16'h0001, 0, 4'd0, 16'hC01A), idle_trc,
             "xxxx", "SBREAK", 16'hC01A, "DEC", "EXEC");
    // Unused state codes
    add_step(0, trc(i_state_e'(3'd6), e_state_e'(4'd14), 0, 16'h0, 0, 4'd0, 16'h0), idle_trc,
             '0, '0, 16'h0, "XXXXX", "xxxx");
    // Switch to core 1, the decode on core 0 is ignored
    add_step(1, trc(I_DEC, E_EXEC, 1, 16'h5A0B, 0, 4'd0, 16'h1111),
             trc(I_IRQ_FETCH, E_IRQ_0, 0, 16'h0, 0, 4'd0, 16'h0),
             '0, '0, 16'h0, "IRQ_FETCH", "IRQ_0");
    add_step(1, trc(I_DEC, E_EXEC, 1, 16'h4090, 0, 4'd0, 16'h2222),
             trc(I_DEC, E_EXEC, 1, 16'h108D, 0, 4'd0, 16'hE100),
             "SWPB", "SWPB r13", 16'hE100, "DEC", "EXEC");
    add_step(1, idle_trc, trc(I_IRQ_DONE, E_IRQ_3, 1, 16'h1234, 1, 4'd13, 16'hE102),
             "IRQ 13", "IRQ 13", 16'hE102, "IRQ_DONE", "IRQ_3");
    add_step(0, trc(I_EXT2, E_DST_WR, 1, 16'h4090, 0, 4'd0, 16'hC020),
             trc(I_DEC, E_EXEC, 1, 16'h60B5, 0, 4'd0, 16'h3333),
             "MOV", "MOV EDE, EDE", 16'hC020, "EXT2", "DST_WR");
    add_step(0, trc(I_EXT2, E_DST_RD, 1, 16'h60B5, 0, 4'd0, 16'hC024), idle_trc,
             "ADDC", "ADDC #N, x(r5)", 16'hC024, "EXT2", "DST_RD");
  endtask

  // ====================
  // Main sequence
  // ====================

  initial
  begin
    int guard;
    idle_trc    = trc(I_IDLE, E_IDLE, 0, 16'h0, 0, 4'd0, 16'h0);
    puc_rst     = 1'b1;
    table_done  = 1'b0;
    core_select = 1'b0;
    core0       = idle_trc;
    core1       = idle_trc;
    exp_short   = '0;
    exp_full    = '0;
    exp_pc      = 16'h0;
    exp_i_state = "IDLE";
    exp_e_state = "IDLE";
    build_table();
    repeat (3) @(posedge mclk);
    #1 puc_rst = 1'b0;
    guard = 0;
    while (!table_done && guard < 400)
    begin
      @(posedge mclk);
      guard++;
    end
    if (!table_done)
    begin
      $display("Timeout: the stimulus table did not finish within 400 cycles");
      $display("Result: FAILED");
    end
    else
    begin
      @(posedge mclk);
      @(negedge mclk);   // Last compare
      $display("Checks: %0d, errors: %0d", check_count, err_count);
      if (err_count == 0 && check_count > 0)
        $display("Result: PASSED");
      else
        $display("Result: FAILED");
    end
    $finish;
  end

  // Table applied after reset, 0 to 3 filler cycles per row
  initial
  begin
    int unsigned seed;
    int          guard;
    int          n_fill;
    seed = 32'h6e68_6729;
    void'($urandom(seed));
    guard = 0;
    while (puc_rst !== 1'b0 && guard < 20)
    begin
      @(posedge mclk);
      guard++;
    end
    if (puc_rst !== 1'b0)
    begin
      $display("Reset was not released within 20 cycles");
      $display("Result: FAILED");
      $finish;
    end
    else
    begin
      #1;
      for (int r = 0; r < n_steps; r++)
      begin
        drive_step(steps[r], 1'b1);
        @(posedge mclk);
        #1;
        n_fill = $urandom % 4;
        for (int k = 0; k < n_fill; k++)
        begin
          drive_step(steps[r], 1'b0);
          @(posedge mclk);
          #1;
        end
      end
      core0       = idle_trc;
      core1       = idle_trc;
      exp_i_state = "IDLE";
      exp_e_state = "IDLE";
      table_done  = 1'b1;
    end
  end

endmodule
